//--- rtl/dbg_types_pkg.sv
package dbg_types_pkg;

    // Parser events toward the controller
    typedef enum logic [2:0] {
        EVT_NONE,
        EVT_RUN,
        EVT_STEP,
        EVT_NEXT,
        EVT_LOAD,                 // 'l' seen, enter load mode
        EVT_LOAD_WORD,
        EVT_LOAD_END
    } dbg_cmd_e;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RUN,
        ST_STEP_WAIT,
        ST_STEP_PULSE,
        ST_LOAD,
        ST_DUMP_FETCH,
        ST_DUMP_SEND,
        ST_DUMP_WAIT
    } dbg_state_e;

    localparam logic [7:0] CHAR_RUN  = 8'h72;   // 'r'
    localparam logic [7:0] CHAR_STEP = 8'h73;   // 's'
    localparam logic [7:0] CHAR_LOAD = 8'h6c;   // 'l'
    localparam logic [7:0] CHAR_NEXT = 8'h6e;   // 'n'

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } rx_byte_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } tx_byte_t;

    typedef struct packed {
        dbg_cmd_e    kind;
        logic [31:0] word;        // Assembled instruction, load events only
        logic        valid;
    } parser_evt_t;

endpackage

//--- rtl/cpu_port_pkg.sv
package cpu_port_pkg;

    localparam int CPU_W = 32;

    // Controller to processor
    typedef struct packed {
        logic       rst;
        logic       clk_en;       // One enable per processor cycle
        logic [4:0] reg_sel;
        logic [7:0] mem_addr;     // Data memory word address
    } cpu_ctrl_t;

    // Processor to controller, selects answered combinationally
    typedef struct packed {
        logic             halt;
        logic [CPU_W-1:0] pc;
        logic [CPU_W-1:0] cycles;
        logic [CPU_W-1:0] reg_data;
        logic [CPU_W-1:0] mem_data;
    } cpu_stat_t;

    // Instruction memory write port
    typedef struct packed {
        logic             we;
        logic [CPU_W-1:0] addr;   // Byte address
        logic [CPU_W-1:0] data;
    } imem_wr_t;

endpackage

//--- rtl/dbg_rx_parser.sv
module dbg_rx_parser
    import dbg_types_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  rx_byte_t    i_rx,
    input  logic        i_load_mode,
    output parser_evt_t o_evt
);

    localparam int WCNT_W = $clog2(IMEM_WORDS + 1);

    logic [31:0]       shift_q;
    logic [31:0]       shift_next;
    logic [1:0]        byte_cnt;
    logic [WCNT_W-1:0] word_cnt;
    logic              mem_full;
    logic              end_word;
    dbg_cmd_e          cmd_kind;
    logic              evt_valid;
    dbg_cmd_e          evt_kind;
    logic [31:0]       evt_word;

    assign shift_next = {shift_q[23:0], i_rx.data};          // MSB first
    assign mem_full   = (word_cnt == WCNT_W'(IMEM_WORDS));
    assign end_word   = (shift_next == '1) || mem_full;      // Past the end also closes the load

    // Command decode, unknown bytes map to no event
    always_comb begin
        case (i_rx.data)
            CHAR_RUN:  cmd_kind = EVT_RUN;
            CHAR_STEP: cmd_kind = EVT_STEP;
            CHAR_LOAD: cmd_kind = EVT_LOAD;
            CHAR_NEXT: cmd_kind = EVT_NEXT;
            default:   cmd_kind = EVT_NONE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            byte_cnt  <= '0;
            word_cnt  <= '0;
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= 1'b0;
            if (!i_load_mode) begin
                byte_cnt <= '0;                              // Next load starts on a word boundary
                word_cnt <= '0;
                if (i_rx.valid && cmd_kind != EVT_NONE) begin
                    evt_valid <= 1'b1;
                end
            end else if (i_rx.valid) begin
                byte_cnt <= byte_cnt + 2'd1;
                if (byte_cnt == 2'd3) begin
                    evt_valid <= 1'b1;
                    if (!end_word) begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
            end
        end
    end

    // Byte assembly and event payload
    always_ff @(posedge i_clk) begin
        if (i_rx.valid) begin
            shift_q  <= shift_next;
            evt_word <= shift_next;
            if (i_load_mode) begin
                evt_kind <= end_word ? EVT_LOAD_END : EVT_LOAD_WORD;
            end else begin
                evt_kind <= cmd_kind;
            end
        end
    end

    assign o_evt = '{kind: evt_kind, word: evt_word, valid: evt_valid};

endmodule

//--- rtl/dbg_tx_serializer.sv
module dbg_tx_serializer
    import dbg_types_pkg::*;
    import cpu_port_pkg::*;
(
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic [CPU_W-1:0] i_word,
    input  logic             i_word_valid,
    input  logic             i_tx_busy,
    output tx_byte_t         o_tx,
    output logic             o_busy
);

    localparam int NBYTES = CPU_W / 8;
    localparam int CNT_W  = $clog2(NBYTES) + 1;

    logic [CPU_W-1:0] shift_q;
    logic [CNT_W-1:0] remain;
    logic             tx_valid;
    logic [7:0]       tx_data;
    logic             send;

    // The strobe cycle itself never samples busy, the UART raises it one cycle later
    assign send = (remain != '0) && !tx_valid && !i_tx_busy;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            remain   <= '0;
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= send;
            if (i_word_valid && remain == '0) begin
                remain <= CNT_W'(NBYTES);
            end else if (send) begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_word_valid && remain == '0) begin
            shift_q <= i_word;
        end else if (send) begin
            shift_q <= {shift_q[CPU_W-9:0], 8'h00};
        end
        if (send) begin
            tx_data <= shift_q[CPU_W-1:CPU_W-8];             // Top byte goes first
        end
    end

    assign o_tx   = '{valid: tx_valid, data: tx_data};
    assign o_busy = (remain != '0);

endmodule

//--- rtl/dbg_control.sv
module dbg_control
    import dbg_types_pkg::*;
    import cpu_port_pkg::*;
#(
    parameter int REG_COUNT  = 32,
    parameter int DMEM_WORDS = 8
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  parser_evt_t      i_evt,
    input  cpu_stat_t        i_cpu,
    input  logic             i_ser_busy,
    output cpu_ctrl_t        o_cpu,
    output imem_wr_t         o_imem,
    output logic [CPU_W-1:0] o_word,
    output logic             o_word_valid,
    output logic             o_load_mode,
    output dbg_state_e       o_state
);

    localparam logic [1:0] PH_PC  = 2'd0;
    localparam logic [1:0] PH_CYC = 2'd1;
    localparam logic [1:0] PH_REG = 2'd2;
    localparam logic [1:0] PH_MEM = 2'd3;

    localparam logic [4:0] REG_LAST = 5'(REG_COUNT - 1);
    localparam logic [7:0] MEM_LAST = 8'(DMEM_WORDS - 1);

    dbg_state_e       state;
    logic             step_mode;
    logic [1:0]       phase;
    logic [4:0]       reg_sel;
    logic [7:0]       mem_addr;
    logic             dump_last;
    logic [CPU_W-1:0] load_addr;
    logic             wr_en;
    logic [CPU_W-1:0] wr_addr;
    logic [CPU_W-1:0] wr_data;
    logic             word_valid;
    logic [CPU_W-1:0] word_q;
    logic [CPU_W-1:0] dump_word;
    logic             cpu_rst;
    logic             clk_en;

    // Selects were set at least one cycle earlier
    always_comb begin
        case (phase)
            PH_PC:   dump_word = i_cpu.pc;
            PH_CYC:  dump_word = i_cpu.cycles;
            PH_REG:  dump_word = i_cpu.reg_data;
            default: dump_word = i_cpu.mem_data;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= ST_IDLE;
            step_mode  <= 1'b0;
            phase      <= PH_PC;
            reg_sel    <= '0;
            mem_addr   <= '0;
            dump_last  <= 1'b0;
            load_addr  <= '0;
            wr_en      <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            wr_en      <= 1'b0;
            word_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_evt.valid) begin
                        case (i_evt.kind)
                            EVT_RUN: begin
                                state     <= ST_RUN;
                                step_mode <= 1'b0;
                            end
                            EVT_STEP: begin
                                state     <= ST_STEP_WAIT;
                                step_mode <= 1'b1;
                            end
                            EVT_LOAD: state <= ST_LOAD;
                            default:  state <= ST_IDLE;
                        endcase
                    end
                end
                ST_RUN: begin
                    if (i_cpu.halt) begin
                        state <= ST_DUMP_FETCH;
                    end
                end
                ST_STEP_WAIT: begin
                    if (i_evt.valid && i_evt.kind == EVT_NEXT) begin
                        state <= ST_STEP_PULSE;
                    end
                end
                ST_STEP_PULSE: state <= ST_DUMP_FETCH;     // Exactly one enable
                ST_LOAD: begin
                    if (i_evt.valid && i_evt.kind == EVT_LOAD_WORD) begin
                        wr_en     <= 1'b1;
                        load_addr <= load_addr + CPU_W'(4);
                    end else if (i_evt.valid && i_evt.kind == EVT_LOAD_END) begin
                        load_addr <= '0;
                        state     <= ST_IDLE;
                    end
                end
                ST_DUMP_FETCH: begin
                    if (!i_ser_busy) begin
                        word_valid <= 1'b1;
                        state      <= ST_DUMP_SEND;
                    end
                end
                ST_DUMP_SEND: begin
                    case (phase)
                        PH_PC:  phase <= PH_CYC;
                        PH_CYC: phase <= PH_REG;
                        PH_REG: begin
                            if (reg_sel == REG_LAST) begin
                                phase <= PH_MEM;
                            end else begin
                                reg_sel <= reg_sel + 5'd1;
                            end
                        end
                        default: begin
                            if (mem_addr == MEM_LAST) begin
                                dump_last <= 1'b1;
                            end else begin
                                mem_addr <= mem_addr + 8'd1;
                            end
                        end
                    endcase
                    state <= ST_DUMP_WAIT;
                end
                ST_DUMP_WAIT: begin
                    if (!i_ser_busy && dump_last) begin    // Last byte is out
                        phase     <= PH_PC;
                        reg_sel   <= '0;
                        mem_addr  <= '0;
                        dump_last <= 1'b0;
                        if (step_mode && !i_cpu.halt) begin
                            state <= ST_STEP_WAIT;
                        end else begin
                            step_mode <= 1'b0;
                            state     <= ST_IDLE;
                        end
                    end else if (!i_ser_busy) begin
                        state <= ST_DUMP_FETCH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Payload registers
    always_ff @(posedge i_clk) begin
        if (state == ST_LOAD && i_evt.valid) begin
            wr_addr <= load_addr;
            wr_data <= i_evt.word;
        end
        if (state == ST_DUMP_FETCH) begin
            word_q <= dump_word;
        end
    end

    assign cpu_rst = (state == ST_IDLE) || (state == ST_LOAD);
    assign clk_en  = (state == ST_RUN && !i_cpu.halt) || (state == ST_STEP_PULSE);

    assign o_cpu        = '{rst: cpu_rst, clk_en: clk_en, reg_sel: reg_sel, mem_addr: mem_addr};
    assign o_imem       = '{we: wr_en, addr: wr_addr, data: wr_data};
    assign o_word       = word_q;
    assign o_word_valid = word_valid;
    assign o_load_mode  = (state == ST_LOAD);
    assign o_state      = state;

endmodule

//--- rtl/dbg_unit_top.sv
module dbg_unit_top
    import dbg_types_pkg::*;
    import cpu_port_pkg::*;
#(
    parameter int REG_COUNT  = 32,
    parameter int DMEM_WORDS = 8,
    parameter int IMEM_WORDS = 256
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  rx_byte_t   i_rx,
    input  logic       i_tx_busy,
    input  cpu_stat_t  i_cpu,
    output tx_byte_t   o_tx,
    output cpu_ctrl_t  o_cpu,
    output imem_wr_t   o_imem,
    output dbg_state_e o_state
);

    parser_evt_t      evt;
    logic             load_mode;
    logic [CPU_W-1:0] word;
    logic             word_valid;
    logic             ser_busy;

    dbg_rx_parser #(
        .IMEM_WORDS (IMEM_WORDS)
    ) dbg_rx_parser_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_rx        (i_rx),
        .i_load_mode (load_mode),
        .o_evt       (evt)
    );

    dbg_control #(
        .REG_COUNT  (REG_COUNT),
        .DMEM_WORDS (DMEM_WORDS)
    ) dbg_control_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_evt        (evt),
        .i_cpu        (i_cpu),
        .i_ser_busy   (ser_busy),
        .o_cpu        (o_cpu),
        .o_imem       (o_imem),
        .o_word       (word),
        .o_word_valid (word_valid),
        .o_load_mode  (load_mode),
        .o_state      (o_state)
    );

    dbg_tx_serializer dbg_tx_serializer_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_word       (word),
        .i_word_valid (word_valid),
        .i_tx_busy    (i_tx_busy),
        .o_tx         (o_tx),
        .o_busy       (ser_busy)
    );

endmodule

//--- sim/dbg_unit_asserts.sv
module dbg_unit_asserts
    import cpu_port_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst,
    input cpu_ctrl_t i_cpu_ctrl,
    input imem_wr_t  i_imem,
    input logic      i_word_valid,
    input logic      i_ser_busy
);

    // One write per load word
    single_write: assert property (
        @(posedge i_clk) disable iff (i_rst) i_imem.we |=> !i_imem.we
    ) else $error("instruction memory write held for two cycles");

    // A processor in reset gets no clock enable
    no_enable_in_reset: assert property (
        @(posedge i_clk) disable iff (i_rst) i_cpu_ctrl.rst |-> !i_cpu_ctrl.clk_en
    ) else $error("clock enable high while processor reset is high");

    word_when_free: assert property (
        @(posedge i_clk) disable iff (i_rst) $rose(i_word_valid) |-> !i_ser_busy
    ) else $error("dump word offered while the serializer is busy");

endmodule

bind dbg_control dbg_unit_asserts dbg_unit_asserts_i (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_cpu_ctrl   (o_cpu),
    .i_imem       (o_imem),
    .i_word_valid (o_word_valid),
    .i_ser_busy   (i_ser_busy)
);

//--- sim/dbg_unit_tb.sv
module dbg_unit_tb
    import dbg_types_pkg::*;
    import cpu_port_pkg::*;
();

    localparam int REG_COUNT    = 32;
    localparam int DMEM_WORDS   = 8;
    localparam int IMEM_WORDS   = 256;
    localparam int DUMP_BYTES   = 4 * (2 + REG_COUNT + DMEM_WORDS);
    localparam int RESET_CYCLES = 16;
    localparam int BYTE_GAP     = 3;              // Idle cycles after each received byte
    localparam int MAX_RECS     = 64;
    localparam int REC_WORDS    = 5;              // kind, data, pc, cycles, halt delay

    localparam logic [31:0] K_BYTE = 32'h00;
    localparam logic [31:0] K_LOAD = 32'h01;
    localparam logic [31:0] K_RUN  = 32'h02;
    localparam logic [31:0] K_STEP = 32'h03;
    localparam logic [31:0] K_END  = 32'hff;

    logic             i_clk;
    logic             i_rst;
    rx_byte_t         i_rx;
    logic             i_tx_busy = 1'b0;
    cpu_stat_t        i_cpu;
    tx_byte_t         o_tx;
    cpu_ctrl_t        o_cpu;
    imem_wr_t         o_imem;
    dbg_state_e       o_state;

    logic             cpu_halt   = 1'b0;
    logic [CPU_W-1:0] cur_pc     = '0;
    logic [CPU_W-1:0] cur_cycles = '0;
    logic [CPU_W-1:0] reg_data;
    logic [CPU_W-1:0] mem_data;

    logic [31:0] tests [0:REC_WORDS*MAX_RECS-1];
    logic [7:0]  tx_exp [$];
    logic [63:0] wr_exp [$];                      // {byte address, data}
    logic [63:0] wr_pair;
    logic [31:0] load_addr = '0;
    logic [31:0] rec_kind;
    logic [31:0] rec_data;
    logic [31:0] rec_pc;
    logic [31:0] rec_cycles;
    logic [31:0] rec_delay;
    int          tx_total   = 0;
    int          wr_total   = 0;
    int          tx_seen    = 0;
    int          wr_seen    = 0;
    int          ce_seen    = 0;
    int          ce_run     = 0;
    int          busy_left  = 0;
    int          halt_delay = 1;
    int          cycle_cnt  = 0;
    int          limit      = 0;
    int          rec_count  = 0;
    int          delay_sum  = 0;

    dbg_unit_top #(
        .REG_COUNT  (REG_COUNT),
        .DMEM_WORDS (DMEM_WORDS),
        .IMEM_WORDS (IMEM_WORDS)
    ) dbg_unit_top_i (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rx      (i_rx),
        .i_tx_busy (i_tx_busy),
        .i_cpu     (i_cpu),
        .o_tx      (o_tx),
        .o_cpu     (o_cpu),
        .o_imem    (o_imem),
        .o_state   (o_state)
    );

    assign i_cpu = '{halt: cpu_halt, pc: cur_pc, cycles: cur_cycles,
                     reg_data: reg_data, mem_data: mem_data};

    // Register and memory selects are answered combinationally
    assign reg_data = 32'h1000_0000 + 32'h0101 * 32'(o_cpu.reg_sel);
    assign mem_data = 32'(o_cpu.mem_addr) ^ 32'hA5A5_0000;

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure("A checked value did not match");
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        @(posedge i_clk);
        i_rx <= '{valid: 1'b1, data: b};
        @(posedge i_clk);
        i_rx <= '{valid: 1'b0, data: b};
        repeat (BYTE_GAP) @(posedge i_clk);
    endtask

    // All expected traffic seen and the FSM parked in the given state
    task automatic wait_for_state(input dbg_state_e target);
        while (tx_seen != tx_total || wr_seen != wr_total || o_state != target) begin
            @(posedge i_clk);
        end
    endtask

    task automatic push_word(input logic [31:0] w);
        for (int i = 3; i >= 0; i--) begin
            tx_exp.push_back(w[8*i +: 8]);        // MSB first on the link
        end
        tx_total += 4;
    endtask

    task automatic push_dump(input logic [31:0] pc, input logic [31:0] cycles);
        push_word(pc);
        push_word(cycles);
        for (int r = 0; r < REG_COUNT; r++) begin
            push_word(32'h1000_0000 + 32'h0101 * 32'(r));
        end
        for (int m = 0; m < DMEM_WORDS; m++) begin
            push_word(32'(m) ^ 32'hA5A5_0000);
        end
    endtask

    task automatic play_byte(input logic [7:0] b);
        int ce_before;
        ce_before = ce_seen;
        send_byte(b);
        if (b == CHAR_LOAD) begin
            load_addr = '0;                       // Every load starts at address 0
            wait_for_state(ST_LOAD);
        end else begin
            repeat (8) @(posedge i_clk);          // Room for any stray response
            wait_for_state(ST_IDLE);
            compare_value("clock enable pulses", 32'(ce_seen - ce_before), 32'd0);
        end
    endtask

    task automatic play_load(input logic [31:0] w);
        if (w != 32'hffff_ffff) begin
            wr_exp.push_back({load_addr, w});
            wr_total++;
            load_addr += 32'd4;
        end
        for (int i = 3; i >= 0; i--) begin
            send_byte(w[8*i +: 8]);
        end
        if (w == 32'hffff_ffff) begin
            wait_for_state(ST_IDLE);
        end else begin
            wait_for_state(ST_LOAD);
        end
    endtask

    task automatic play_run(input logic [31:0] pc, input logic [31:0] cycles, input int delay);
        int ce_before;
        cur_pc     <= pc;
        cur_cycles <= cycles;
        halt_delay = delay;
        ce_before  = ce_seen;
        push_dump(pc, cycles);
        send_byte(CHAR_RUN);
        wait_for_state(ST_IDLE);
        compare_value("clock enable pulses", 32'(ce_seen - ce_before), 32'(delay));
    endtask

    task automatic play_step(input int steps, input logic [31:0] pc,
                             input logic [31:0] cycles, input int delay);
        int ce_before;
        cur_pc     <= pc;
        cur_cycles <= cycles;
        halt_delay = delay;
        send_byte(CHAR_STEP);
        wait_for_state(ST_STEP_WAIT);
        for (int s = 1; s <= steps; s++) begin
            ce_before = ce_seen;
            push_dump(pc, cycles);
            send_byte(CHAR_NEXT);
            if (s >= delay) begin
                wait_for_state(ST_IDLE);          // Halt ends step mode
            end else begin
                wait_for_state(ST_STEP_WAIT);
            end
            compare_value("clock enable pulses", 32'(ce_seen - ce_before), 32'd1);
        end
    endtask

    // Processor halt counts clock enables since the last processor reset
    always @(posedge i_clk) begin
        if (o_cpu.rst) begin
            ce_run = 0;
            cpu_halt <= 1'b0;
        end else if (o_cpu.clk_en) begin
            ce_run = ce_run + 1;
            if (ce_run >= halt_delay) begin
                cpu_halt <= 1'b1;
            end
        end
        if (!i_rst && o_cpu.clk_en) begin
            ce_seen <= ce_seen + 1;
        end
    end

    // UART model with a random busy time after every byte
    always @(posedge i_clk) begin
        if (o_tx.valid) begin
            busy_left = $urandom % 6;
        end else if (busy_left != 0) begin
            busy_left = busy_left - 1;
        end
        i_tx_busy <= (busy_left != 0);
    end

    always @(posedge i_clk) begin
        if (!i_rst && o_tx.valid) begin
            if (tx_exp.size() == 0) begin
                stop_with_failure("A byte was sent on the link when none was expected");
            end else begin
                compare_value("o_tx.data", 32'(o_tx.data), 32'(tx_exp.pop_front()));
                tx_seen <= tx_seen + 1;
            end
        end
    end

    always @(posedge i_clk) begin
        if (!i_rst && o_imem.we) begin
            if (wr_exp.size() == 0) begin
                stop_with_failure("Instruction memory was written when no write was expected");
            end else begin
                wr_pair = wr_exp.pop_front();
                compare_value("o_imem.addr", o_imem.addr, wr_pair[63:32]);
                compare_value("o_imem.data", o_imem.data, wr_pair[31:0]);
                wr_seen <= wr_seen + 1;
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            stop_with_failure("Timeout: the tests did not finish within the cycle limit");
        end
    end

    initial begin
        void'($urandom(32'h1547_dc46));
        i_rst <= 1'b1;
        i_rx  <= '0;
        $readmemh("sim/dbg_unit_tests.txt", tests);
        while (rec_count < MAX_RECS && tests[REC_WORDS*rec_count] != K_END) begin
            delay_sum += int'(tests[REC_WORDS*rec_count+4]);
            rec_count++;
        end
        // Worst case of six cycles per dump byte for every record
        limit = RESET_CYCLES + rec_count * DUMP_BYTES * 6 + delay_sum;
        if (rec_count == 0) begin
            stop_with_failure("No test records could be read from the test file");
        end

        repeat (RESET_CYCLES) @(posedge i_clk);
        i_rst <= 1'b0;
        repeat (4) begin
            @(posedge i_clk);
            compare_value("o_tx.valid", 32'(o_tx.valid), 32'd0);
            compare_value("o_imem.we", 32'(o_imem.we), 32'd0);
            compare_value("o_cpu.clk_en", 32'(o_cpu.clk_en), 32'd0);
            compare_value("o_cpu.rst", 32'(o_cpu.rst), 32'd1);
        end

        for (int r = 0; r < rec_count; r++) begin
            rec_kind   = tests[REC_WORDS*r];
            rec_data   = tests[REC_WORDS*r+1];
            rec_pc     = tests[REC_WORDS*r+2];
            rec_cycles = tests[REC_WORDS*r+3];
            rec_delay  = tests[REC_WORDS*r+4];
            case (rec_kind)
                K_BYTE:  play_byte(rec_data[7:0]);
                K_LOAD:  play_load(rec_data);
                K_RUN:   play_run(rec_pc, rec_cycles, int'(rec_delay));
                K_STEP:  play_step(int'(rec_data), rec_pc, rec_cycles, int'(rec_delay));
                default: stop_with_failure("Unknown record kind in the test file");
            endcase
        end

        repeat (20) @(posedge i_clk);             // Late bytes or writes show up here
        $display("Verification passed");
        $finish;
    end

endmodule

//--- sim/dbg_unit_tests.txt
// Columns: kind, data, pc, cycles, halt delay (hex, one record per line)
// Kind 0 raw byte, 1 load word, 2 run, 3 step with data = count of 'n' bytes, ff ends the list
00 00000078 00000000 00000000 00
00 0000006c 00000000 00000000 00
01 3c010040 00000000 00000000 00
01 34210010 00000000 00000000 00
01 8c220000 00000000 00000000 00
01 ac220004 00000000 00000000 00
01 ffffffff 00000000 00000000 00
02 00000000 00400010 00000004 04
00 00000041 00000000 00000000 00
00 0000006e 00000000 00000000 00
03 00000003 00400020 00000007 03
00 0000006c 00000000 00000000 00
01 12345678 00000000 00000000 00
01 ffffffff 00000000 00000000 00
02 00000000 0040abc0 00000019 19
03 00000001 00400004 00000001 01
00 0000003f 00000000 00000000 00
02 00000000 00400100 00000002 02
00 0000006c 00000000 00000000 00
01 deadbeef 00000000 00000000 00
01 00000000 00000000 00000000 00
01 0badf00d 00000000 00000000 00
01 ffffffff 00000000 00000000 00
03 00000002 00400008 00000002 02
00 00000000 00000000 00000000 00
02 00000000 00400200 0000000a 0a
ff 00000000 00000000 00000000 00

//--- all.f
rtl/dbg_types_pkg.sv
rtl/cpu_port_pkg.sv
rtl/dbg_rx_parser.sv
rtl/dbg_tx_serializer.sv
rtl/dbg_control.sv
rtl/dbg_unit_top.sv
sim/dbg_unit_asserts.sv
sim/dbg_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run from the project root, then judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dbg_unit_tb \
    -f all.f -o dbg_unit_sim \
    && ./obj_dir/dbg_unit_sim > sim.log 2>&1 \
    || echo "Verification failed" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && echo "FAIL" && exit 1 || echo "PASS" && exit 0
